/* Makefile */
SOURCES := $(shell cat mips_top.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mips_top: mips_top.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_top -f mips_top.f

run: obj_dir/Vtb_mips_top
	@out="$$(./obj_dir/Vtb_mips_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* mips_decode.sv */
`timescale 1ns/100ps

module mips_decode (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_step,
    input  logic [mips_pkg::XLEN-1:0]       i_instr,
    input  logic [mips_pkg::XLEN-1:0]       i_pc4,
    input  logic                            i_flush,
    input  logic                            i_wb_we,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_wb_idx,
    input  logic [mips_pkg::XLEN-1:0]       i_wb_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg_idx,
    output logic                            o_stall,
    output logic                            o_halt_seen,
    output logic [mips_pkg::XLEN-1:0]       o_dbg_reg_data,
    output mips_pkg::alu_op_e               o_ex_alu_op,
    output logic                            o_ex_alu_src_imm,
    output logic                            o_ex_reg_write,
    output logic                            o_ex_mem_read,
    output logic                            o_ex_mem_write,
    output logic                            o_ex_mem_to_reg,
    output logic                            o_ex_branch,
    output logic                            o_ex_branch_ne,
    output logic                            o_ex_halt,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rs,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_rt,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_dest,
    output logic [mips_pkg::XLEN-1:0]       o_ex_rs_val,
    output logic [mips_pkg::XLEN-1:0]       o_ex_rt_val,
    output logic [mips_pkg::XLEN-1:0]       o_ex_imm,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_ex_shamt,
    output logic [mips_pkg::XLEN-1:0]       o_ex_pc4
);
    import mips_pkg::*;

    logic [XLEN-1:0]       regs [32];
    opcode_e               opcode;
    logic [REG_ADDR_W-1:0] rs, rt, rd, dest;
    logic [IMM_W-1:0]      imm;
    alu_op_e               alu_op;
    logic                  alu_src_imm, reg_write, mem_read, mem_write, mem_to_reg;
    logic                  branch, branch_ne, zero_ext, uses_rt;
    logic                  load_use, halt_in_id, halt_seen_q, bubble;

    assign opcode = opcode_e'(i_instr[XLEN-1:OPC_LSB]);
    assign rs     = i_instr[RS_LSB +: REG_ADDR_W];
    assign rt     = i_instr[RT_LSB +: REG_ADDR_W];
    assign rd     = i_instr[RD_LSB +: REG_ADDR_W];
    assign imm    = i_instr[IMM_W-1:0];

    always_comb begin
        alu_op      = ADD;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        zero_ext    = 1'b0;
        uses_rt     = 1'b0;
        dest        = rt;
        case (opcode)
            OPC_RTYPE: begin
                alu_src_imm = 1'b0;
                uses_rt     = 1'b1;
                dest        = rd;
                case (funct_e'(i_instr[SHAMT_LSB-1:0]))
                    F_ADDU:  alu_op = ADD;
                    F_SUBU:  alu_op = SUB;
                    F_AND:   alu_op = AND;
                    F_OR:    alu_op = OR;
                    F_XOR:   alu_op = XOR;
                    F_SLT:   alu_op = SLT;
                    F_SLL:   alu_op = SLL;
                    F_SRL:   alu_op = SRL;
                    default: reg_write = 1'b0;
                endcase
            end
            OPC_ADDIU: alu_op = ADD;
            OPC_ANDI: begin
                alu_op   = AND;
                zero_ext = 1'b1;
            end
            OPC_ORI: begin
                alu_op   = OR;
                zero_ext = 1'b1;
            end
            OPC_LUI: alu_op = LUI;
            OPC_LW: begin
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            OPC_SW, OPC_BEQ, OPC_BNE: begin
                reg_write = 1'b0;
                uses_rt   = 1'b1;
                mem_write = (opcode == OPC_SW);
                branch    = (opcode != OPC_SW);
                branch_ne = (opcode == OPC_BNE);
            end
            default: reg_write = 1'b0;
        endcase
    end

    // Load in EX whose result the current instruction needs
    assign load_use = o_ex_mem_read && (o_ex_dest != '0) &&
                      ((o_ex_dest == rs) || (uses_rt && o_ex_dest == rt));
    assign halt_in_id  = (opcode == OPC_HALT);
    assign o_stall     = load_use;
    assign o_halt_seen = halt_in_id || halt_seen_q;
    assign bubble      = i_flush || load_use || halt_seen_q;

    always_ff @(posedge i_clk) begin
        if (i_step && i_wb_we) begin
            regs[i_wb_idx] <= i_wb_data;
        end
    end

    assign o_dbg_reg_data = (i_dbg_reg_idx == '0) ? '0 : regs[i_dbg_reg_idx];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            {o_ex_reg_write, o_ex_mem_read, o_ex_mem_write, o_ex_mem_to_reg} <= '0;
            {o_ex_branch, o_ex_branch_ne, o_ex_halt, o_ex_alu_src_imm} <= '0;
            o_ex_alu_op <= ADD;
            o_ex_rs     <= '0;
            o_ex_rt     <= '0;
            o_ex_dest   <= '0;
            halt_seen_q <= 1'b0;
        end else if (i_step) begin
            o_ex_alu_op      <= alu_op;
            o_ex_alu_src_imm <= alu_src_imm;
            o_ex_reg_write   <= !bubble && reg_write && (dest != '0);
            o_ex_mem_read    <= !bubble && mem_read;
            o_ex_mem_write   <= !bubble && mem_write;
            o_ex_mem_to_reg  <= !bubble && mem_to_reg;
            o_ex_branch      <= !bubble && branch;
            o_ex_branch_ne   <= branch_ne;
            o_ex_halt        <= !bubble && halt_in_id;
            o_ex_rs          <= rs;
            o_ex_rt          <= rt;
            o_ex_dest        <= dest;
            // Only one halt enters the pipe
            if (!bubble && halt_in_id) begin
                halt_seen_q <= 1'b1;
            end
        end
    end

    // Operand reads bypass the word being written back
    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_ex_rs_val <= (rs == '0) ? '0 : (i_wb_we && i_wb_idx == rs) ? i_wb_data : regs[rs];
            o_ex_rt_val <= (rt == '0) ? '0 : (i_wb_we && i_wb_idx == rt) ? i_wb_data : regs[rt];
            o_ex_imm    <= zero_ext ? {{(XLEN-IMM_W){1'b0}}, imm}
                                    : {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
            o_ex_shamt  <= i_instr[SHAMT_LSB +: REG_ADDR_W];
            o_ex_pc4    <= i_pc4;
        end
    end

    a_no_r0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb_we |-> i_wb_idx != '0);

endmodule

/* mips_execute.sv */
`timescale 1ns/100ps

module mips_execute (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_step,
    input  mips_pkg::alu_op_e               i_ex_alu_op,
    input  logic                            i_ex_alu_src_imm,
    input  logic                            i_ex_reg_write,
    input  logic                            i_ex_mem_read,
    input  logic                            i_ex_mem_write,
    input  logic                            i_ex_mem_to_reg,
    input  logic                            i_ex_branch,
    input  logic                            i_ex_branch_ne,
    input  logic                            i_ex_halt,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rs,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_rt,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_dest,
    input  logic [mips_pkg::XLEN-1:0]       i_ex_rs_val,
    input  logic [mips_pkg::XLEN-1:0]       i_ex_rt_val,
    input  logic [mips_pkg::XLEN-1:0]       i_ex_imm,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_ex_shamt,
    input  logic [mips_pkg::XLEN-1:0]       i_ex_pc4,
    input  logic [mips_pkg::XLEN-1:0]       i_exmem_fwd_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_exmem_fwd_idx,
    input  logic                            i_exmem_fwd_we,
    input  logic [mips_pkg::XLEN-1:0]       i_memwb_fwd_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_memwb_fwd_idx,
    input  logic                            i_memwb_fwd_we,
    output logic                            o_redirect,
    output logic [mips_pkg::XLEN-1:0]       o_target,
    output logic [mips_pkg::XLEN-1:0]       o_mem_result,
    output logic [mips_pkg::XLEN-1:0]       o_mem_store_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_mem_dest,
    output logic                            o_mem_reg_write,
    output logic                            o_mem_mem_read,
    output logic                            o_mem_mem_write,
    output logic                            o_mem_mem_to_reg,
    output logic                            o_mem_halt
);
    import mips_pkg::*;

    fwd_sel_e        sel_a, sel_b;
    logic [XLEN-1:0] op_a, op_rt, op_b, result;

    // Newest producer first and r0 never forwarded
    function automatic fwd_sel_e fwd_pick(input logic [REG_ADDR_W-1:0] idx);
        if (idx == '0) return FWD_NONE;
        if (i_exmem_fwd_we && i_exmem_fwd_idx == idx) return FWD_EXMEM;
        if (i_memwb_fwd_we && i_memwb_fwd_idx == idx) return FWD_MEMWB;
        return FWD_NONE;
    endfunction

    always_comb begin
        sel_a = fwd_pick(i_ex_rs);
        sel_b = fwd_pick(i_ex_rt);
        op_a  = (sel_a == FWD_EXMEM) ? i_exmem_fwd_data :
                (sel_a == FWD_MEMWB) ? i_memwb_fwd_data : i_ex_rs_val;
        op_rt = (sel_b == FWD_EXMEM) ? i_exmem_fwd_data :
                (sel_b == FWD_MEMWB) ? i_memwb_fwd_data : i_ex_rt_val;
        op_b  = i_ex_alu_src_imm ? i_ex_imm : op_rt;
        case (i_ex_alu_op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            OR:      result = op_a | op_b;
            XOR:     result = op_a ^ op_b;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLL:     result = op_b << i_ex_shamt;
            SRL:     result = op_b >> i_ex_shamt;
            LUI:     result = {op_b[XLEN-IMM_W-1:0], {IMM_W{1'b0}}};
            default: result = '0;
        endcase
    end

    assign o_redirect = i_ex_branch && ((op_a == op_rt) != i_ex_branch_ne);
    assign o_target   = i_ex_pc4 + {i_ex_imm[XLEN-3:0], 2'b00};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_dest       <= '0;
            o_mem_reg_write  <= 1'b0;
            o_mem_mem_read   <= 1'b0;
            o_mem_mem_write  <= 1'b0;
            o_mem_mem_to_reg <= 1'b0;
            o_mem_halt       <= 1'b0;
        end else if (i_step) begin
            o_mem_dest       <= i_ex_dest;
            o_mem_reg_write  <= i_ex_reg_write;
            o_mem_mem_read   <= i_ex_mem_read;
            o_mem_mem_write  <= i_ex_mem_write;
            o_mem_mem_to_reg <= i_ex_mem_to_reg;
            o_mem_halt       <= i_ex_halt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_mem_result     <= result;
            o_mem_store_data <= op_rt;
        end
    end

    // The instruction behind a taken branch is squashed by decode
    a_flush_after_redirect: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_redirect && i_step) |=> !o_redirect);

endmodule

/* mips_fetch.sv */
`timescale 1ns/100ps

module mips_fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_step,
    input  logic                      i_stall,
    input  logic                      i_redirect,
    input  logic [mips_pkg::XLEN-1:0] i_target,
    input  logic                      i_imem_we,
    input  logic [mips_pkg::XLEN-1:0] i_imem_addr,
    input  logic [mips_pkg::XLEN-1:0] i_imem_data,
    output logic [mips_pkg::XLEN-1:0] o_pc,
    output logic [mips_pkg::XLEN-1:0] o_ifid_instr,
    output logic [mips_pkg::XLEN-1:0] o_ifid_pc4
);
    import mips_pkg::*;

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc4;

    assign pc4 = o_pc + XLEN'(4);

    // Load port is word indexed and ignores the step enable
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr[IDX_W-1:0]] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc         <= '0;
            o_ifid_instr <= '0;
            o_ifid_pc4   <= '0;
        end else if (i_step) begin
            // Redirect wins over stall and squashes the fetched word
            if (i_redirect) begin
                o_pc         <= i_target;
                o_ifid_instr <= '0;
                o_ifid_pc4   <= '0;
            end else if (!i_stall) begin
                o_pc         <= pc4;
                o_ifid_instr <= imem[o_pc[IDX_W+1:2]];
                o_ifid_pc4   <= pc4;
            end
        end
    end

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_step |=> o_pc[1:0] == 2'b00);

endmodule

/* mips_golden.hex */
// Columns: tag index value, all hex
// Tag 1 program word at word index, 2 expected register, 3 expected memory at byte address
1 00 3C011234 // lui   r1, 0x1234
1 01 34215678 // ori   r1, r1, 0x5678
1 02 2402FFFD // addiu r2, r0, -3
1 03 00221821 // addu  r3, r1, r2
1 04 00612023 // subu  r4, r3, r1
1 05 00232826 // xor   r5, r1, r3
1 06 0041302A // slt   r6, r2, r1
1 07 0022382A // slt   r7, r1, r2
1 08 00054100 // sll   r8, r5, 4
1 09 00024F02 // srl   r9, r2, 28
1 0A 304AF0F0 // andi  r10, r2, 0xf0f0
1 0B 01095825 // or    r11, r8, r9
1 0C 240C0020 // addiu r12, r0, 0x20
1 0D AD8B0004 // sw    r11, 4(r12)
1 0E 8D8D0004 // lw    r13, 4(r12)
1 0F 01AD7021 // addu  r14, r13, r13
1 10 AD8E0000 // sw    r14, 0(r12)
1 11 240F0055 // addiu r15, r0, 0x55
1 12 10C60002 // beq   r6, r6, +2
1 13 240F0099 // addiu r15, r0, 0x99
1 14 25EF0001 // addiu r15, r15, 1
1 15 14E00001 // bne   r7, r0, +1
1 16 24100077 // addiu r16, r0, 0x77
1 17 FC000000 // halt
2 01 12345678
2 02 FFFFFFFD
2 03 12345675
2 04 FFFFFFFD
2 05 0000000D
2 06 00000001
2 07 00000000
2 08 000000D0
2 09 0000000F
2 0A 0000F0F0
2 0B 000000DF
2 0C 00000020
2 0D 000000DF
2 0E 000001BE
2 0F 00000055
2 10 00000077
3 20 000001BE
3 24 000000DF

/* mips_memory.sv */
`timescale 1ns/100ps

module mips_memory #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_step,
    input  logic [mips_pkg::XLEN-1:0]       i_mem_result,
    input  logic [mips_pkg::XLEN-1:0]       i_mem_store_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_mem_dest,
    input  logic                            i_mem_reg_write,
    input  logic                            i_mem_mem_read,
    input  logic                            i_mem_mem_write,
    input  logic                            i_mem_mem_to_reg,
    input  logic                            i_mem_halt,
    input  logic [mips_pkg::XLEN-1:0]       i_dbg_mem_addr,
    output logic                            o_wb_we,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_wb_idx,
    output logic [mips_pkg::XLEN-1:0]       o_wb_data,
    output logic [mips_pkg::XLEN-1:0]       o_dbg_mem_data,
    output logic                            o_halt,
    output logic [mips_pkg::XLEN-1:0]       o_exmem_fwd_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_exmem_fwd_idx,
    output logic                            o_exmem_fwd_we,
    output logic [mips_pkg::XLEN-1:0]       o_memwb_fwd_data,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_memwb_fwd_idx,
    output logic                            o_memwb_fwd_we
);
    import mips_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] dmem [DMEM_DEPTH];
    logic [XLEN-1:0] wb_load, wb_result;
    logic            wb_mem_to_reg;

    always_ff @(posedge i_clk) begin
        if (i_step && i_mem_mem_write) begin
            dmem[i_mem_result[IDX_W+1:2]] <= i_mem_store_data;
        end
        if (i_step) begin
            wb_load   <= dmem[i_mem_result[IDX_W+1:2]];
            wb_result <= i_mem_result;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_we       <= 1'b0;
            o_wb_idx      <= '0;
            wb_mem_to_reg <= 1'b0;
            o_halt        <= 1'b0;
        end else if (i_step) begin
            o_wb_we       <= i_mem_reg_write;
            o_wb_idx      <= i_mem_dest;
            wb_mem_to_reg <= i_mem_mem_to_reg;
            // Sticky flag that rises as the halt enters MEM/WB
            if (i_mem_halt) begin
                o_halt <= 1'b1;
            end
        end
    end

    assign o_wb_data      = wb_mem_to_reg ? wb_load : wb_result;
    assign o_dbg_mem_data = dmem[i_dbg_mem_addr[IDX_W+1:2]];

    // A load address is not its result
    assign o_exmem_fwd_data = i_mem_result;
    assign o_exmem_fwd_idx  = i_mem_dest;
    assign o_exmem_fwd_we   = i_mem_reg_write && !i_mem_mem_read;
    assign o_memwb_fwd_data = o_wb_data;
    assign o_memwb_fwd_idx  = o_wb_idx;
    assign o_memwb_fwd_we   = o_wb_we;

    a_store_in_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_step && i_mem_mem_write) |-> i_mem_result[XLEN-1:2] < DMEM_DEPTH);

endmodule

/* mips_pkg.sv */
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Field boundaries inside one instruction word
    localparam int OPC_LSB   = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int IMM_W     = 16;

    typedef enum logic [5:0] {
        OPC_RTYPE = 6'h00,
        OPC_BEQ   = 6'h04,
        OPC_BNE   = 6'h05,
        OPC_ADDIU = 6'h09,
        OPC_ANDI  = 6'h0C,
        OPC_ORI   = 6'h0D,
        OPC_LUI   = 6'h0F,
        OPC_LW    = 6'h23,
        OPC_SW    = 6'h2B,
        OPC_HALT  = 6'h3F
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,
        SLL = 4'd6,
        SRL = 4'd7,
        LUI = 4'd8
    } alu_op_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_NONE  = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_e;

endpackage

/* mips_top.f */
mips_pkg.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_top.sv
tb_clock_gen.sv
tb_mips_top.sv

/* mips_top.sv */
`timescale 1ns/100ps

module mips_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_step,
    input  logic                            i_imem_we,
    input  logic [mips_pkg::XLEN-1:0]       i_imem_addr,
    input  logic [mips_pkg::XLEN-1:0]       i_imem_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg_idx,
    input  logic [mips_pkg::XLEN-1:0]       i_dbg_mem_addr,
    output logic [mips_pkg::XLEN-1:0]       o_pc,
    output logic                            o_halt,
    output logic [mips_pkg::XLEN-1:0]       o_dbg_reg_data,
    output logic [mips_pkg::XLEN-1:0]       o_dbg_mem_data
);
    import mips_pkg::*;

    logic                  step, stall, halt_seen, redirect;
    logic [XLEN-1:0]       target, ifid_instr, ifid_pc4;
    alu_op_e               ex_alu_op;
    logic                  ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic                  ex_mem_to_reg, ex_branch, ex_branch_ne, ex_halt;
    logic [REG_ADDR_W-1:0] ex_rs, ex_rt, ex_dest, ex_shamt;
    logic [XLEN-1:0]       ex_rs_val, ex_rt_val, ex_imm, ex_pc4;
    logic [XLEN-1:0]       mem_result, mem_store_data;
    logic [REG_ADDR_W-1:0] mem_dest;
    logic                  mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg, mem_halt;
    logic                  wb_we, exmem_fwd_we, memwb_fwd_we;
    logic [REG_ADDR_W-1:0] wb_idx, exmem_fwd_idx, memwb_fwd_idx;
    logic [XLEN-1:0]       wb_data, exmem_fwd_data, memwb_fwd_data;

    // Pipeline freezes for good once the halt retires
    assign step = i_step && !o_halt;

    mips_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_step(step),
        .i_stall(stall || halt_seen), .i_redirect(redirect), .i_target(target),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .o_pc(o_pc), .o_ifid_instr(ifid_instr), .o_ifid_pc4(ifid_pc4)
    );

    mips_decode u_decode (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_step(step),
        .i_instr(ifid_instr), .i_pc4(ifid_pc4), .i_flush(redirect),
        .i_wb_we(wb_we), .i_wb_idx(wb_idx), .i_wb_data(wb_data),
        .i_dbg_reg_idx(i_dbg_reg_idx), .o_stall(stall), .o_halt_seen(halt_seen),
        .o_dbg_reg_data(o_dbg_reg_data), .o_ex_alu_op(ex_alu_op),
        .o_ex_alu_src_imm(ex_alu_src_imm), .o_ex_reg_write(ex_reg_write),
        .o_ex_mem_read(ex_mem_read), .o_ex_mem_write(ex_mem_write),
        .o_ex_mem_to_reg(ex_mem_to_reg), .o_ex_branch(ex_branch),
        .o_ex_branch_ne(ex_branch_ne), .o_ex_halt(ex_halt), .o_ex_rs(ex_rs),
        .o_ex_rt(ex_rt), .o_ex_dest(ex_dest), .o_ex_rs_val(ex_rs_val),
        .o_ex_rt_val(ex_rt_val), .o_ex_imm(ex_imm), .o_ex_shamt(ex_shamt), .o_ex_pc4(ex_pc4)
    );

    mips_execute u_execute (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_step(step),
        .i_ex_alu_op(ex_alu_op), .i_ex_alu_src_imm(ex_alu_src_imm),
        .i_ex_reg_write(ex_reg_write), .i_ex_mem_read(ex_mem_read),
        .i_ex_mem_write(ex_mem_write), .i_ex_mem_to_reg(ex_mem_to_reg),
        .i_ex_branch(ex_branch), .i_ex_branch_ne(ex_branch_ne), .i_ex_halt(ex_halt),
        .i_ex_rs(ex_rs), .i_ex_rt(ex_rt), .i_ex_dest(ex_dest), .i_ex_rs_val(ex_rs_val),
        .i_ex_rt_val(ex_rt_val), .i_ex_imm(ex_imm), .i_ex_shamt(ex_shamt), .i_ex_pc4(ex_pc4),
        .i_exmem_fwd_data(exmem_fwd_data), .i_exmem_fwd_idx(exmem_fwd_idx),
        .i_exmem_fwd_we(exmem_fwd_we), .i_memwb_fwd_data(memwb_fwd_data),
        .i_memwb_fwd_idx(memwb_fwd_idx), .i_memwb_fwd_we(memwb_fwd_we),
        .o_redirect(redirect), .o_target(target), .o_mem_result(mem_result),
        .o_mem_store_data(mem_store_data), .o_mem_dest(mem_dest),
        .o_mem_reg_write(mem_reg_write), .o_mem_mem_read(mem_mem_read),
        .o_mem_mem_write(mem_mem_write), .o_mem_mem_to_reg(mem_mem_to_reg),
        .o_mem_halt(mem_halt)
    );

    mips_memory #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_step(step),
        .i_mem_result(mem_result), .i_mem_store_data(mem_store_data),
        .i_mem_dest(mem_dest), .i_mem_reg_write(mem_reg_write),
        .i_mem_mem_read(mem_mem_read), .i_mem_mem_write(mem_mem_write),
        .i_mem_mem_to_reg(mem_mem_to_reg), .i_mem_halt(mem_halt),
        .i_dbg_mem_addr(i_dbg_mem_addr), .o_wb_we(wb_we), .o_wb_idx(wb_idx),
        .o_wb_data(wb_data), .o_dbg_mem_data(o_dbg_mem_data), .o_halt(o_halt),
        .o_exmem_fwd_data(exmem_fwd_data), .o_exmem_fwd_idx(exmem_fwd_idx),
        .o_exmem_fwd_we(exmem_fwd_we), .o_memwb_fwd_data(memwb_fwd_data),
        .o_memwb_fwd_idx(memwb_fwd_idx), .o_memwb_fwd_we(memwb_fwd_we)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

/* tb_mips_top.sv */
`timescale 1ns/100ps

module tb_mips_top;
    import mips_pkg::*;

    localparam int          GOLDEN_WORDS     = 256;
    localparam int          CYCLES_PER_INSTR = 40;
    localparam int          POST_HALT_CYCLES = 20;
    localparam logic [31:0] TAG_PROG         = 32'h1;
    localparam logic [31:0] TAG_REG          = 32'h2;
    localparam logic [31:0] TAG_MEM          = 32'h3;

    logic                  clk;
    logic                  arst_n;
    logic                  step;
    logic                  imem_we;
    logic [XLEN-1:0]       imem_addr;
    logic [XLEN-1:0]       imem_data;
    logic [REG_ADDR_W-1:0] dbg_reg_idx;
    logic [XLEN-1:0]       dbg_mem_addr;
    logic [XLEN-1:0]       pc;
    logic                  halt;
    logic [XLEN-1:0]       dbg_reg_data;
    logic [XLEN-1:0]       dbg_mem_data;

    logic [31:0]           golden [GOLDEN_WORDS];
    logic [31:0]           rng;
    logic [XLEN-1:0]       held_pc;
    int                    num_instr;
    int                    num_checks;
    bit                    loaded;

    tb_clock_gen #(.PERIOD_NS(100)) u_clock_gen (.o_clk(clk));

    mips_top #(
        .IMEM_DEPTH(256),
        .DMEM_DEPTH(64)
    ) u_mips_top (
        .i_clk(clk), .i_arst_n(arst_n), .i_step(step),
        .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
        .i_dbg_reg_idx(dbg_reg_idx), .i_dbg_mem_addr(dbg_mem_addr),
        .o_pc(pc), .o_halt(halt),
        .o_dbg_reg_data(dbg_reg_data), .o_dbg_mem_data(dbg_mem_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    // Program words go in with the pipeline held
    task automatic load_program();
        int idx;
        for (idx = 0; idx + 2 < GOLDEN_WORDS; idx += 3) begin
            if (golden[idx] == TAG_PROG) begin
                @(negedge clk);
                imem_we   = 1'b1;
                imem_addr = golden[idx + 1];
                imem_data = golden[idx + 2];
                num_instr++;
            end
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    // Checks the PC held over an unstepped cycle and draws the next step
    task automatic next_step_cycle();
        @(negedge clk);
        if (!step) begin
            assert (pc === held_pc) else
                fail_run($sformatf("CHECK FAILED: o_pc 0x%08h, held 0x%08h with i_step low",
                                   pc, held_pc));
        end
        held_pc = pc;
        rng     = xorshift32(rng);
        step    = (rng[1:0] != 2'b00);
    endtask

    task automatic check_register(input logic [31:0] idx, input logic [31:0] expected);
        @(negedge clk);
        dbg_reg_idx = idx[REG_ADDR_W-1:0];
        @(posedge clk);
        assert (dbg_reg_data === expected) else
            fail_run($sformatf("CHECK FAILED: o_dbg_reg_data r%0d got 0x%08h expected 0x%08h",
                               idx, dbg_reg_data, expected));
    endtask

    task automatic check_memory(input logic [31:0] addr, input logic [31:0] expected);
        @(negedge clk);
        dbg_mem_addr = addr;
        @(posedge clk);
        assert (dbg_mem_data === expected) else
            fail_run($sformatf("CHECK FAILED: o_dbg_mem_data @0x%08h got 0x%08h expected 0x%08h",
                               addr, dbg_mem_data, expected));
    endtask

    task automatic check_results();
        int idx;
        for (idx = 0; idx + 2 < GOLDEN_WORDS; idx += 3) begin
            case (golden[idx])
                32'h0, TAG_PROG: begin
                end
                TAG_REG: begin
                    num_checks++;
                    check_register(golden[idx + 1], golden[idx + 2]);
                end
                TAG_MEM: begin
                    num_checks++;
                    check_memory(golden[idx + 1], golden[idx + 2]);
                end
                default: fail_run($sformatf("golden file entry %0d has an unknown tag %0h",
                                            idx / 3, golden[idx]));
            endcase
        end
    endtask

    initial begin : main
        int              idx;
        logic [XLEN-1:0] halt_pc;
        arst_n       = 1'b0;
        step         = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_idx  = '0;
        dbg_mem_addr = '0;
        rng          = 32'h78b7;
        held_pc      = '0;
        num_instr    = 0;
        num_checks   = 0;
        loaded       = 1'b0;
        for (idx = 0; idx < GOLDEN_WORDS; idx++) begin
            golden[idx] = '0;
        end
        $readmemh("mips_golden.hex", golden);

        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        load_program();
        assert (pc === '0) else
            fail_run($sformatf("CHECK FAILED: o_pc 0x%08h after loading, expected 0x00000000", pc));
        loaded = 1'b1;

        while (halt !== 1'b1) begin
            next_step_cycle();
        end

        // Frozen after halt whatever i_step does
        halt_pc = pc;
        repeat (POST_HALT_CYCLES) begin
            next_step_cycle();
            assert (halt === 1'b1) else
                fail_run($sformatf("CHECK FAILED: o_halt 0x%0h after halt, expected 0x1", halt));
            assert (pc === halt_pc) else
                fail_run($sformatf("CHECK FAILED: o_pc 0x%08h after halt, expected 0x%08h",
                                   pc, halt_pc));
        end
        step = 1'b0;

        check_results();
        if (num_checks > 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("golden file holds no register or memory expectations");
            $display("Simulation finished: FAIL");
            $fatal(1, "nothing was checked");
        end
    end

    // Budget in stepped cycles per program word
    initial begin : watchdog
        int limit;
        int stepped;
        wait (loaded);
        limit   = CYCLES_PER_INSTR * num_instr;
        stepped = 0;
        while (stepped < limit) begin
            @(posedge clk);
            if (step) begin
                stepped++;
            end
        end
        fail_run($sformatf("timeout: program did not finish within %0d stepped cycles", limit));
    end

endmodule
